/* conv_pkg.sv */
`default_nettype none

package conv_pkg;

    ////////////////////////////////////////////////////////////
    // Engine sizes
    ////////////////////////////////////////////////////////////
    localparam int BIT_WIDTH     = 8;
    localparam int NUM_CHANNEL   = 3;
    localparam int NUM_KERNEL    = 4;
    localparam int NUM_TAP       = 3;
    localparam int TAP_IDX_WIDTH = 2;

    // Flat word widths at the top level
    localparam int PIXEL_WIDTH  = BIT_WIDTH * NUM_CHANNEL;
    localparam int WEIGHT_WIDTH = BIT_WIDTH * NUM_CHANNEL * NUM_KERNEL;
    localparam int PSUM_WIDTH   = BIT_WIDTH * NUM_KERNEL;

    ////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////
    typedef logic [BIT_WIDTH-1:0] sample_t;

    // Channel c at bits 8c and up
    typedef sample_t [NUM_CHANNEL-1:0] pixel_t;

    // Kernel n, channel c at offset 24n+8c
    typedef pixel_t [NUM_KERNEL-1:0] weight_t;

    typedef sample_t [NUM_KERNEL-1:0] psum_t;

    // Tap 0 holds the oldest pixel
    typedef pixel_t  [NUM_TAP-1:0] window_t;
    typedef weight_t [NUM_TAP-1:0] tap_weights_t;
    typedef psum_t   [NUM_TAP-1:0] tap_psum_t;

endpackage

`default_nettype wire

/* conv_if.sv */
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////
// Pixel window, line buffer to PE array
////////////////////////////////////////////////////////////
interface pixel_window_if import conv_pkg::*; ();

    window_t win;
    // New pixel entered the window this cycle
    logic    win_val;
    // Window holds K pixels of the current line
    logic    win_ok;
    // Newest pixel is the last one of the line
    logic    win_last;

    modport src (
        output win,
        output win_val,
        output win_ok,
        output win_last
    );

    modport dst (
        input win,
        input win_val,
        input win_ok,
        input win_last
    );

endinterface

////////////////////////////////////////////////////////////
// Per-tap sums, PE array to router
////////////////////////////////////////////////////////////
interface tap_psum_if import conv_pkg::*; ();

    tap_psum_t tap_psum;
    // Window flags one stage later
    logic      psum_val;
    logic      psum_ok;
    logic      psum_last;

    modport src (
        output tap_psum,
        output psum_val,
        output psum_ok,
        output psum_last
    );

    modport dst (
        input tap_psum,
        input psum_val,
        input psum_ok,
        input psum_last
    );

endinterface

`default_nettype wire

/* line_window_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module line_window_buffer import conv_pkg::*; #(
    parameter int CNT_WIDTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  pixel_t                   i_data,
    input  logic                     i_data_take,
    input  logic [TAP_IDX_WIDTH-1:0] i_kernel_width,
    input  logic [CNT_WIDTH-1:0]     i_line_width,
    input  logic                     i_enable,
    pixel_window_if.src              win
);

    logic [CNT_WIDTH-1:0]     pix_idx;
    logic [CNT_WIDTH-1:0]     k_ext;
    logic [TAP_IDX_WIDTH-1:0] k_last;
    logic                     idx_last;

    assign k_ext    = CNT_WIDTH'(i_kernel_width);
    assign k_last   = i_kernel_width - 1'b1;
    assign idx_last = (pix_idx == i_line_width - 1'b1);

    // Pixel position within the line
    always_ff @(posedge clk) begin
        if (rst || !i_enable) begin
            pix_idx <= '0;
        end else if (i_data_take) begin
            pix_idx <= idx_last ? '0 : pix_idx + 1'b1;
        end
    end

    // Newest pixel lands on tap K-1, older ones move down toward tap 0.
    // Taps above K-1 are left alone, their weights read as zero
    always_ff @(posedge clk) begin
        if (i_data_take) begin
            for (int t = 0; t < NUM_TAP; t++) begin
                if (t == k_last) begin
                    win.win[t] <= i_data;
                end else if (t < k_last && t < NUM_TAP - 1) begin
                    win.win[t] <= win.win[t+1];
                end
            end
        end
    end

    // Flags registered together with the window
    always_ff @(posedge clk) begin
        if (rst) begin
            win.win_val  <= 1'b0;
            win.win_ok   <= 1'b0;
            win.win_last <= 1'b0;
        end else begin
            win.win_val  <= i_data_take;
            win.win_ok   <= i_data_take && (pix_idx >= k_ext - 1'b1);
            win.win_last <= i_data_take && idx_last;
        end
    end

endmodule

`default_nettype wire

/* weight_store.sv */
`timescale 1ns/10ps
`default_nettype none

module weight_store import conv_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_enable,
    input  logic                     i_done,
    input  logic [TAP_IDX_WIDTH-1:0] i_kernel_width,
    input  weight_t                  i_weight,
    input  logic                     i_weight_val,
    output logic                     o_weight_req,
    output tap_weights_t             o_tap_weights,
    output logic                     o_loaded
);

    tap_weights_t             w_reg;
    logic [TAP_IDX_WIDTH-1:0] w_cnt;
    logic                     w_take;
    logic                     w_cnt_last;

    assign w_take     = i_weight_val && o_weight_req;
    assign w_cnt_last = (w_cnt == i_kernel_width - 1'b1);

    ////////////////////////////////////////////////////////////
    // Request and load control
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst || !i_enable) begin
            o_weight_req <= 1'b0;
            o_loaded     <= 1'b0;
            w_cnt        <= '0;
        end else if (w_take) begin
            if (w_cnt_last) begin
                // Last tap word, request drops on this edge
                w_cnt        <= '0;
                o_loaded     <= 1'b1;
                o_weight_req <= 1'b0;
            end else begin
                w_cnt <= w_cnt + 1'b1;
            end
        end else begin
            o_weight_req <= !o_loaded && !i_done;
        end
    end

    // Tap registers, written in arrival order
    always_ff @(posedge clk) begin
        if (w_take) begin
            w_reg[w_cnt] <= i_weight;
        end
    end

    // Unused taps read as zero
    for (genvar t = 0; t < NUM_TAP; t++) begin : g_mask
        assign o_tap_weights[t] = (TAP_IDX_WIDTH'(t) < i_kernel_width) ? w_reg[t] : '0;
    end

endmodule

`default_nettype wire

/* kernel_channel_pe.sv */
`timescale 1ns/10ps
`default_nettype none

module kernel_channel_pe import conv_pkg::*; (
    input  logic    clk,
    input  pixel_t  i_pixel,
    input  weight_t i_weight,
    output psum_t   o_psum
);

    psum_t dot;

    ////////////////////////////////////////////////////////////
    // Channel dot product per kernel
    ////////////////////////////////////////////////////////////
    always_comb begin
        for (int n = 0; n < NUM_KERNEL; n++) begin
            dot[n] = '0;
            for (int c = 0; c < NUM_CHANNEL; c++) begin
                // Sum kept at sample width, wraps modulo 256
                dot[n] = dot[n] + sample_t'(i_pixel[c] * i_weight[n][c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        o_psum <= dot;
    end

endmodule

`default_nettype wire

/* kcpe_array.sv */
`timescale 1ns/10ps
`default_nettype none

module kcpe_array import conv_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  tap_weights_t i_tap_weights,
    pixel_window_if.dst  win,
    tap_psum_if.src      tp
);

    tap_psum_t pe_psum;

    ////////////////////////////////////////////////////////////
    // One PE per window tap
    ////////////////////////////////////////////////////////////
    for (genvar t = 0; t < NUM_TAP; t++) begin : g_pe
        kernel_channel_pe u_pe (
            .clk      (clk),
            .i_pixel  (win.win[t]),
            .i_weight (i_tap_weights[t]),
            .o_psum   (pe_psum[t])
        );
    end

    assign tp.tap_psum = pe_psum;

    // Flags follow the PE register stage
    always_ff @(posedge clk) begin
        if (rst) begin
            tp.psum_val  <= 1'b0;
            tp.psum_ok   <= 1'b0;
            tp.psum_last <= 1'b0;
        end else begin
            tp.psum_val  <= win.win_val;
            tp.psum_ok   <= win.win_ok;
            tp.psum_last <= win.win_last;
        end
    end

endmodule

`default_nettype wire

/* result_router.sv */
`timescale 1ns/10ps
`default_nettype none

module result_router import conv_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    tap_psum_if.dst tp,
    output psum_t   o_psum,
    output logic    o_psum_val,
    output logic    o_psum_end
);

    psum_t total;
    logic  pos_ok;

    ////////////////////////////////////////////////////////////
    // Tap sums per kernel
    ////////////////////////////////////////////////////////////
    always_comb begin
        for (int n = 0; n < NUM_KERNEL; n++) begin
            total[n] = '0;
            for (int t = 0; t < NUM_TAP; t++) begin
                total[n] = total[n] + tp.tap_psum[t][n];
            end
        end
    end

    // Positions before K-1 never reach the output
    assign pos_ok = tp.psum_val && tp.psum_ok;

    always_ff @(posedge clk) begin
        o_psum <= total;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_psum_val <= 1'b0;
            o_psum_end <= 1'b0;
        end else begin
            o_psum_val <= pos_ok;
            o_psum_end <= pos_ok && tp.psum_last;
        end
    end

endmodule

`default_nettype wire

/* engine_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module engine_ctrl #(
    parameter int CNT_WIDTH = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_enable,
    input  logic                 i_loaded,
    input  logic                 i_psum_end,
    input  logic [CNT_WIDTH-1:0] i_num_lines,
    output logic                 o_data_req,
    output logic                 o_done
);

    logic [CNT_WIDTH-1:0] line_cnt;
    logic                 final_end;

    // L-th line end seen this cycle
    assign final_end = i_psum_end && (line_cnt == i_num_lines - 1'b1);

    ////////////////////////////////////////////////////////////
    // Line count and done
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst || !i_enable) begin
            line_cnt <= '0;
            o_done   <= 1'b0;
        end else if (final_end) begin
            o_done <= 1'b1;
        end else if (i_psum_end && !o_done) begin
            line_cnt <= line_cnt + 1'b1;
        end
    end

    // Data request drops on the same edge that raises done
    always_ff @(posedge clk) begin
        if (rst) begin
            o_data_req <= 1'b0;
        end else begin
            o_data_req <= i_enable && i_loaded && !o_done && !final_end;
        end
    end

endmodule

`default_nettype wire

/* line_conv_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module line_conv_engine import conv_pkg::*; #(
    parameter int CNT_WIDTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_enable,
    input  logic [TAP_IDX_WIDTH-1:0] i_conf_kernel_width,
    input  logic [CNT_WIDTH-1:0]     i_conf_line_width,
    input  logic [CNT_WIDTH-1:0]     i_conf_num_lines,
    input  logic [WEIGHT_WIDTH-1:0]  i_weight,
    input  logic                     i_weight_val,
    input  logic [PIXEL_WIDTH-1:0]   i_data,
    input  logic                     i_data_val,
    output logic                     o_weight_req,
    output logic                     o_data_req,
    output logic [PSUM_WIDTH-1:0]    o_psum,
    output logic                     o_psum_val,
    output logic                     o_psum_end,
    output logic                     o_done
);

    pixel_t       data_px;
    weight_t      weight_word;
    psum_t        out_psum;
    tap_weights_t tap_weights;
    logic         weights_loaded;
    logic         data_take;

    pixel_window_if u_win_if ();
    tap_psum_if     u_tp_if ();

    ////////////////////////////////////////////////////////////
    // Word casts and pixel take strobe
    ////////////////////////////////////////////////////////////
    assign data_px     = pixel_t'(i_data);
    assign weight_word = weight_t'(i_weight);
    assign o_psum      = out_psum;
    assign data_take   = i_data_val && o_data_req;

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////
    line_window_buffer #(
        .CNT_WIDTH (CNT_WIDTH)
    ) u_window (
        .clk            (clk),
        .rst            (rst),
        .i_data         (data_px),
        .i_data_take    (data_take),
        .i_kernel_width (i_conf_kernel_width),
        .i_line_width   (i_conf_line_width),
        .i_enable       (i_enable),
        .win            (u_win_if.src)
    );

    weight_store u_weights (
        .clk            (clk),
        .rst            (rst),
        .i_enable       (i_enable),
        .i_done         (o_done),
        .i_kernel_width (i_conf_kernel_width),
        .i_weight       (weight_word),
        .i_weight_val   (i_weight_val),
        .o_weight_req   (o_weight_req),
        .o_tap_weights  (tap_weights),
        .o_loaded       (weights_loaded)
    );

    kcpe_array u_pe_array (
        .clk           (clk),
        .rst           (rst),
        .i_tap_weights (tap_weights),
        .win           (u_win_if.dst),
        .tp            (u_tp_if.src)
    );

    result_router u_router (
        .clk        (clk),
        .rst        (rst),
        .tp         (u_tp_if.dst),
        .o_psum     (out_psum),
        .o_psum_val (o_psum_val),
        .o_psum_end (o_psum_end)
    );

    // Control
    engine_ctrl #(
        .CNT_WIDTH (CNT_WIDTH)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .i_enable    (i_enable),
        .i_loaded    (weights_loaded),
        .i_psum_end  (o_psum_end),
        .i_num_lines (i_conf_num_lines),
        .o_data_req  (o_data_req),
        .o_done      (o_done)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD     = 40.0,
    parameter int  RST_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // Reset released a little after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

`default_nettype wire

/* line_conv_engine_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module line_conv_engine_sva (
    input logic clk,
    input logic rst,
    input logic o_weight_req,
    input logic o_data_req,
    input logic o_psum_val,
    input logic o_psum_end,
    input logic o_done
);

    // Failed assertions so far
    int fail_cnt = 0;

    end_needs_val: assert property (@(posedge clk) disable iff (rst)
        o_psum_end |-> o_psum_val)
        else begin
            $error("o_psum_end without o_psum_val");
            fail_cnt++;
        end

    req_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(o_weight_req && o_data_req))
        else begin
            $error("weight and data requests high together");
            fail_cnt++;
        end

    // No result while done and done only after a line end
    done_quiet: assert property (@(posedge clk) disable iff (rst)
        o_done |-> !o_psum_val)
        else begin
            $error("result while done is high");
            fail_cnt++;
        end

    done_after_end: assert property (@(posedge clk) disable iff (rst)
        $rose(o_done) |-> $past(o_psum_end))
        else begin
            $error("done rose without a line end before it");
            fail_cnt++;
        end

    reset_clears: assert property (@(posedge clk)
        rst |=> (!o_weight_req && !o_data_req && !o_psum_val && !o_psum_end && !o_done))
        else begin
            $error("control outputs not low after reset");
            fail_cnt++;
        end

endmodule

bind line_conv_engine line_conv_engine_sva u_sva (.*);

`default_nettype wire

/* line_conv_engine_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module line_conv_engine_tb import conv_pkg::*; ();

    localparam int NUM_CASES = 6;

    logic                     clk;
    logic                     rst;
    logic                     i_enable;
    logic [TAP_IDX_WIDTH-1:0] i_conf_kernel_width;
    logic [7:0]               i_conf_line_width;
    logic [7:0]               i_conf_num_lines;
    logic [WEIGHT_WIDTH-1:0]  i_weight;
    logic                     i_weight_val;
    logic [PIXEL_WIDTH-1:0]   i_data;
    logic                     i_data_val;
    logic                     o_weight_req;
    logic                     o_data_req;
    logic [PSUM_WIDTH-1:0]    o_psum;
    logic                     o_psum_val;
    logic                     o_psum_end;
    logic                     o_done;

    ////////////////////////////////////////////////////////////
    // Case table with K=3 first so every window tap gets known data
    ////////////////////////////////////////////////////////////
    string case_name [0:NUM_CASES-1] = '{"k3_w8_l2", "k1_w5_l3_gap", "k2_w6_l2",
                                         "k3_w3_l2_gap", "k2_w12_l1_gap", "k1_w4_l2"};
    int    case_k    [0:NUM_CASES-1] = '{3, 1, 2, 3, 2, 1};
    int    case_w    [0:NUM_CASES-1] = '{8, 5, 6, 3, 12, 4};
    int    case_l    [0:NUM_CASES-1] = '{2, 3, 2, 2, 1, 2};
    int    case_gap  [0:NUM_CASES-1] = '{0, 1, 0, 1, 1, 0};

    logic [31:0] seed = 32'd62;
    int          err_cnt = 0;
    int          result_cnt = 0;
    int          wrap_cnt = 0;
    int          cyc_cnt = 0;
    int          cyc_limit = 0;
    int          last_end_cyc = 0;
    string       cur_name = "reset";

    // Reference model state
    logic [7:0]            w_ref [0:NUM_TAP-1][0:NUM_KERNEL-1][0:NUM_CHANNEL-1];
    logic [PIXEL_WIDTH-1:0] line_px [0:255];
    int                    line_pos;
    logic [PSUM_WIDTH-1:0] exp_psum [$];
    logic                  exp_end [$];
    int                    exp_cyc [$];
    logic [PSUM_WIDTH-1:0] want_psum;
    logic                  want_end;
    int                    want_cyc;

    tb_clock_gen #(.PERIOD(40.0), .RST_CYCLES(8)) u_clk (.clk(clk), .rst(rst));

    line_conv_engine #(.CNT_WIDTH(8)) uut (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic draw_byte(output logic [7:0] b);
        seed = lcg_next(seed);
        b = seed[23:16];
    endtask

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        err_cnt++;
        $display("Fail %s %s: expected %0h, actual %0h", test, what, exp, act);
    endtask

    task automatic report_error(input string test, input string msg);
        err_cnt++;
        $display("Error in %s: %s", test, msg);
    endtask

    ////////////////////////////////////////////////////////////
    // Weight load with request checks
    ////////////////////////////////////////////////////////////
    task automatic load_weights(input int k);
        logic [WEIGHT_WIDTH-1:0] word;
        @(negedge clk);
        while (!o_weight_req) @(negedge clk);
        for (int t = 0; t < k; t++) begin
            for (int n = 0; n < NUM_KERNEL; n++) begin
                for (int c = 0; c < NUM_CHANNEL; c++) begin
                    draw_byte(w_ref[t][n][c]);
                    word[24*n+8*c +: 8] = w_ref[t][n][c];
                end
            end
            @(posedge clk);
            #2;
            i_weight     = word;
            i_weight_val = 1'b1;
            @(negedge clk);
            if (o_weight_req !== 1'b1) report_mismatch(cur_name, "o_weight_req", 1, o_weight_req);
            if (o_data_req !== 1'b0) report_mismatch(cur_name, "o_data_req", 0, o_data_req);
        end
        @(posedge clk);
        #2;
        i_weight_val = 1'b0;
        @(negedge clk);
        if (o_weight_req !== 1'b0) report_mismatch(cur_name, "o_weight_req", 0, o_weight_req);
    endtask

    // Output rule applied to the pixel just taken
    task automatic model_take(input logic [PIXEL_WIDTH-1:0] px, input int k, input int w);
        int                    pos;
        int                    raw;
        logic [PSUM_WIDTH-1:0] res;
        line_px[line_pos] = px;
        if (line_pos >= k - 1) begin
            pos = line_pos - k + 1;
            for (int n = 0; n < NUM_KERNEL; n++) begin
                raw = 0;
                for (int t = 0; t < k; t++) begin
                    for (int c = 0; c < NUM_CHANNEL; c++) begin
                        raw += line_px[pos+t][8*c +: 8] * w_ref[t][n][c];
                    end
                end
                if (raw > 255) wrap_cnt++;
                res[8*n +: 8] = raw % 256;
            end
            exp_psum.push_back(res);
            exp_end.push_back(line_pos == w - 1);
            exp_cyc.push_back(cyc_cnt);
        end
        line_pos = (line_pos == w - 1) ? 0 : line_pos + 1;
    endtask

    task automatic stream_lines(input int k, input int w, input int l, input int gap);
        int         taken;
        logic [7:0] r;
        taken = 0;
        while (taken < l * w) begin
            @(posedge clk);
            #2;
            i_data_val = 1'b1;
            if (gap != 0) begin
                draw_byte(r);
                if (r[1:0] == 2'd0) i_data_val = 1'b0;
            end
            for (int c = 0; c < NUM_CHANNEL; c++) begin
                draw_byte(r);
                i_data[8*c +: 8] = r;
            end
            @(negedge clk);
            if (i_data_val && o_data_req) begin
                model_take(i_data, k, w);
                taken++;
            end
        end
        @(posedge clk);
        #2;
        i_data_val = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Done check, extra strobes and enable drop
    ////////////////////////////////////////////////////////////
    task automatic finish_case();
        @(negedge clk);
        while (!o_done) @(negedge clk);
        if (cyc_cnt != last_end_cyc + 1) report_error(cur_name, "o_done late after line end");
        if (exp_psum.size() != 0) report_mismatch(cur_name, "pending", 0, exp_psum.size());
        if (o_data_req !== 1'b0) report_mismatch(cur_name, "o_data_req", 0, o_data_req);
        repeat (6) begin
            @(posedge clk);
            #2;
            i_data_val = 1'b1;
            @(negedge clk);
            if (o_done !== 1'b1) report_mismatch(cur_name, "o_done", 1, o_done);
        end
        @(posedge clk);
        #2;
        i_data_val = 1'b0;
        i_enable   = 1'b0;
        @(posedge clk);
        @(negedge clk);
        if (o_done !== 1'b0) report_mismatch(cur_name, "o_done", 0, o_done);
    endtask

    // Result monitor
    always @(negedge clk) begin
        if (!rst && o_psum_val === 1'b1) begin
            if (exp_psum.size() == 0) begin
                report_error(cur_name, "result appeared with none expected");
            end else begin
                want_psum = exp_psum.pop_front();
                want_end  = exp_end.pop_front();
                want_cyc  = exp_cyc.pop_front();
                result_cnt++;
                if (o_psum !== want_psum) report_mismatch(cur_name, "o_psum", want_psum, o_psum);
                if (o_psum_end !== want_end) begin
                    report_mismatch(cur_name, "o_psum_end", want_end, o_psum_end);
                end
                if (cyc_cnt - want_cyc != 3) begin
                    report_mismatch(cur_name, "latency", 3, cyc_cnt - want_cyc);
                end
            end
        end
        if (!rst && o_psum_end === 1'b1) begin
            last_end_cyc = cyc_cnt;
            if (o_psum_val !== 1'b1) report_error(cur_name, "o_psum_end high without o_psum_val");
        end
    end

    // Cycle limit
    always @(posedge clk) begin
        cyc_cnt = cyc_cnt + 1;
        if (cyc_limit > 0 && cyc_cnt >= cyc_limit) begin
            $display("Timeout after %0d cycles in %s", cyc_cnt, cur_name);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        i_enable            = 1'b0;
        i_conf_kernel_width = '0;
        i_conf_line_width   = '0;
        i_conf_num_lines    = '0;
        i_weight            = '0;
        i_weight_val        = 1'b0;
        i_data              = '0;
        i_data_val          = 1'b0;
        for (int i = 0; i < NUM_CASES; i++) begin
            cyc_limit += case_k[i] + case_l[i] * case_w[i] * 3 + 40;
        end
        @(negedge clk);
        while (rst) @(negedge clk);
        if ({o_weight_req, o_data_req, o_psum_val, o_psum_end, o_done} !== 5'b0) begin
            report_mismatch("reset", "control outputs", 0,
                            {o_weight_req, o_data_req, o_psum_val, o_psum_end, o_done});
        end
        for (int i = 0; i < NUM_CASES; i++) begin
            cur_name = case_name[i];
            line_pos = 0;
            @(posedge clk);
            #2;
            i_conf_kernel_width = case_k[i];
            i_conf_line_width   = case_w[i];
            i_conf_num_lines    = case_l[i];
            i_enable            = 1'b1;
            load_weights(case_k[i]);
            stream_lines(case_k[i], case_w[i], case_l[i], case_gap[i]);
            finish_case();
        end
        if (wrap_cnt == 0) report_error("all", "no result wrapped modulo 256");
        $display("Results checked: %0d, errors: %0d, assertion failures: %0d",
                 result_cnt, err_cnt, uut.u_sva.fail_cnt);
        if (err_cnt == 0 && uut.u_sva.fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
conv_pkg.sv
conv_if.sv
line_window_buffer.sv
weight_store.sv
kernel_channel_pe.sv
kcpe_array.sv
result_router.sv
engine_ctrl.sv
line_conv_engine.sv
tb_clock_gen.sv
line_conv_engine_sva.sv
line_conv_engine_tb.sv
